/* logic/vicTimingPkg.sv */
/*
 * Raster timing definitions for the video fetch engine.
 * Slot kinds, line layout and sprite counts.
 */

package vicTimingPkg;

	// ============================================================
	// Slot kinds
	// ============================================================

	// Kind of fetch slot walked by the sequencer
	typedef enum logic [1:0] {
		slotRef,
		slotChar,
		slotSprite,
		slotIdle
	} slotKind_e;

	// ============================================================
	// Line and frame layout
	// ============================================================

	// Refresh slots at the start of every line
	localparam int REF_SLOTS = 5;
	// Matrix/graphic slot pairs per line
	localparam int CHAR_COLS = 40;
	// Sprite groups per line, one pointer fetch each
	localparam int MIBCNT = 8;
	// Data fetches that follow each sprite pointer
	localparam int SPR_DATA = 3;
	// Scanlines per character row
	localparam int ROW_LINES = 8;
	// Character rows per frame
	localparam int TEXT_ROWS = 25;

endpackage

/* logic/vicMemPkg.sv */
/*
 * Video memory definitions.
 * Address and data widths, credit depth, fetch kinds,
 * the decoded view of a returned word and sprite pointer offsets.
 */

package vicMemPkg;

	// Video address and returned data widths
	localparam int ADDR_W = 14;
	localparam int DATA_W = 12;

	// Requests the external memory can hold at once
	localparam int CREDITS = 4;

	// Kind of fetch, carried with every request and returned word
	typedef enum logic [2:0] {
		kindRef,
		kindMatrix,
		kindGfx,
		kindSprPtr,
		kindSprData
	} fetchKind_e;

	// A matrix word carries colour in the top nibble and the character code below
	typedef struct packed {
		logic [3:0] colour;
		logic [7:0] code;
	} matrixView_t;

	// A sprite pointer word only uses the low byte
	typedef struct packed {
		logic [3:0] unused;
		logic [7:0] pointer;
	} ptrView_t;

	// One returned word, read through whichever view its kind calls for
	typedef union packed {
		matrixView_t matrix;
		ptrView_t ptr;
	} fetchWord_u;

	// Sprite pointers sit at the end of the video matrix
	localparam logic [ADDR_W-1:0] SPR_PTR40 = 14'h03F8;
	localparam logic [ADDR_W-1:0] SPR_PTR80 = 14'h07F0;

endpackage

/* logic/vicIfs.sv */
/*
 * Interfaces between the fetch engine blocks.
 * slotIf from sequencer to address generator, fetchReqIf from
 * address generator to issue block, fetchRetIf for decoded returns.
 */
`timescale 1ns/1ns

// One fetch slot, transferred when valid and ready are both high
interface slotIf;
	logic valid;
	vicTimingPkg::slotKind_e kind;
	// High half of the old phi02 cycle
	logic phase;
	logic [10:0] vmIndex;
	logic [2:0] scanline;
	logic [2:0] spriteNum;
	logic [7:0] refCount;
	logic ready;

	modport source(output valid, kind, phase, vmIndex, scanline, spriteNum, refCount,
		input ready);
	modport sink(input valid, kind, phase, vmIndex, scanline, spriteNum, refCount,
		output ready);
endinterface

// A formed video address waiting for a credit
interface fetchReqIf;
	logic valid;
	logic [vicMemPkg::ADDR_W-1:0] addr;
	vicMemPkg::fetchKind_e kind;
	logic [2:0] spriteNum;
	logic ready;

	modport source(output valid, addr, kind, spriteNum, input ready);
	modport sink(input valid, addr, kind, spriteNum, output ready);
endinterface

// Returned words the address generator depends on, as single-cycle pulses
interface fetchRetIf;
	logic charValid;
	logic [7:0] charCode;
	logic ptrValid;
	logic [2:0] ptrNum;
	logic [7:0] ptrValue;

	modport source(output charValid, charCode, ptrValid, ptrNum, ptrValue);
	modport sink(input charValid, charCode, ptrValid, ptrNum, ptrValue);
endinterface

/* logic/vicSlotSequencer.sv */
/*
 * Slot sequencer for the video fetch engine.
 * Walks refresh, matrix/graphic and sprite slots across each line,
 * and the scanline, row base and refresh counters across the frame.
 */
`timescale 1ns/1ns

module vicSlotSequencer (
	input logic clk33,
	input logic arstN,
	slotIf.source slot
);

	// Column position, with one value for the whole sprite region
	logic [5:0] slotPos;
	logic phase;
	logic [2:0] spriteNum;
	logic [1:0] sprIdx;
	logic [2:0] scanline;
	logic [10:0] rowBase;
	logic [7:0] refCount;
	logic started;
	logic xfer;
	logic inRef;
	logic inChar;
	logic [5:0] column;
	logic lastRef;
	logic lastCol;
	logic lastData;
	logic lastSprite;
	logic lastLine;
	logic lastRow;

	// ============================================================
	// Position decode
	// ============================================================

	assign xfer = slot.valid && slot.ready;
	assign inRef = slotPos < 6'(vicTimingPkg::REF_SLOTS);
	assign inChar = !inRef &&
		(slotPos < 6'(vicTimingPkg::REF_SLOTS + vicTimingPkg::CHAR_COLS));
	assign column = slotPos - 6'(vicTimingPkg::REF_SLOTS);

	assign lastRef = slotPos == 6'(vicTimingPkg::REF_SLOTS - 1);
	assign lastCol = slotPos == 6'(vicTimingPkg::REF_SLOTS + vicTimingPkg::CHAR_COLS - 1);
	assign lastData = sprIdx == 2'(vicTimingPkg::SPR_DATA - 1);
	assign lastSprite = spriteNum == 3'(vicTimingPkg::MIBCNT - 1);
	assign lastLine = scanline == 3'(vicTimingPkg::ROW_LINES - 1);
	assign lastRow = rowBase ==
		11'((vicTimingPkg::TEXT_ROWS - 1) * vicTimingPkg::CHAR_COLS);

	// Slot outputs come straight from the counters
	assign slot.valid = started;
	assign slot.phase = phase;
	assign slot.vmIndex = rowBase + {5'b00000, column};
	assign slot.scanline = scanline;
	assign slot.spriteNum = spriteNum;
	assign slot.refCount = refCount;

	always_comb begin
		if (!started)
			slot.kind = vicTimingPkg::slotIdle;
		else if (inRef)
			slot.kind = vicTimingPkg::slotRef;
		else if (inChar)
			slot.kind = vicTimingPkg::slotChar;
		else
			slot.kind = vicTimingPkg::slotSprite;
	end

	// ============================================================
	// Counters, stepped only on a transfer
	// ============================================================

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			started <= 1'b0;
			slotPos <= 6'd0;
			phase <= 1'b0;
			spriteNum <= 3'd0;
			sprIdx <= 2'd0;
			scanline <= 3'd0;
			rowBase <= 11'd0;
			refCount <= 8'hFF;
		end else begin
			started <= 1'b1;
			if (xfer) begin
				if (inRef) begin
					refCount <= refCount - 8'd1;
					slotPos <= slotPos + 6'd1;
					// The first matrix fetch takes the high phase
					phase <= lastRef;
				end else if (inChar) begin
					if (phase)
						phase <= 1'b0;
					else begin
						slotPos <= slotPos + 6'd1;
						// Past the last column the sprite pointer comes in the low phase
						phase <= !lastCol;
					end
				end else if (!phase) begin
					// Pointer done, data fetches follow in the high phase
					phase <= 1'b1;
					sprIdx <= 2'd0;
				end else if (!lastData)
					sprIdx <= sprIdx + 2'd1;
				else begin
					sprIdx <= 2'd0;
					phase <= 1'b0;
					if (!lastSprite)
						spriteNum <= spriteNum + 3'd1;
					else begin
						// End of line
						spriteNum <= 3'd0;
						slotPos <= 6'd0;
						if (!lastLine)
							scanline <= scanline + 3'd1;
						else begin
							scanline <= 3'd0;
							// Wrap the frame after the last character row
							rowBase <= lastRow ? 11'd0 :
								rowBase + 11'(vicTimingPkg::CHAR_COLS);
						end
					end
				end
			end
		end
	end

endmodule

/* logic/vicAddressGen.sv */
/*
 * Address generator for the video fetch engine.
 * Forms the video address for each slot, registers it as a request,
 * and keeps the last character code, sprite pointers and data counters.
 */
`timescale 1ns/1ns

module vicAddressGen (
	input logic clk33,
	input logic arstN,
	input logic col80,
	input logic bmm,
	input logic ecm,
	input logic [13:0] vm,
	input logic [13:0] cb,
	slotIf.sink slot,
	fetchReqIf.source req,
	fetchRetIf.sink ret
);

	logic [7:0] charCode;
	logic charSeen;
	logic [vicTimingPkg::MIBCNT-1:0] ptrSeen;
	logic [7:0] sprPtr [vicTimingPkg::MIBCNT];
	logic [5:0] sprCnt [vicTimingPkg::MIBCNT];
	logic [13:0] sprOffset;
	logic [13:0] addrNext;
	vicMemPkg::fetchKind_e kindNext;
	logic depOk;
	logic stageFree;
	logic take;
	logic frameStart;

	assign sprOffset = col80 ? vicMemPkg::SPR_PTR80 : vicMemPkg::SPR_PTR40;

	// ============================================================
	// Address forming
	// ============================================================

	always_comb begin
		addrNext = 14'h3FFF;
		kindNext = vicMemPkg::kindRef;
		case (slot.kind)
			vicTimingPkg::slotRef:
				addrNext = {6'b111111, slot.refCount};
			vicTimingPkg::slotChar: begin
				if (slot.phase) begin
					addrNext = vm + {3'b000, slot.vmIndex};
					kindNext = vicMemPkg::kindMatrix;
				end else begin
					kindNext = vicMemPkg::kindGfx;
					if (bmm)
						addrNext = {1'b0, cb[13], 12'd0} + {slot.vmIndex, slot.scanline};
					else
						addrNext = {cb[13:11], charCode, slot.scanline};
					// Extended colour steals two code bits for the background select
					if (ecm)
						addrNext[10:9] = 2'b00;
				end
			end
			vicTimingPkg::slotSprite: begin
				if (!slot.phase) begin
					addrNext = vm + sprOffset + {11'd0, slot.spriteNum};
					kindNext = vicMemPkg::kindSprPtr;
				end else begin
					addrNext = {sprPtr[slot.spriteNum], sprCnt[slot.spriteNum]};
					kindNext = vicMemPkg::kindSprData;
				end
			end
			default: ;
		endcase
	end

	// Graphic and sprite data slots wait for the word they depend on
	always_comb begin
		depOk = 1'b1;
		if (slot.kind == vicTimingPkg::slotChar && !slot.phase)
			depOk = charSeen;
		else if (slot.kind == vicTimingPkg::slotSprite && slot.phase)
			depOk = ptrSeen[slot.spriteNum];
	end

	assign stageFree = !req.valid || req.ready;
	assign slot.ready = stageFree && depOk;
	assign take = slot.valid && slot.ready;
	assign frameStart = take && slot.kind == vicTimingPkg::slotChar && slot.phase &&
		slot.vmIndex == 11'd0 && slot.scanline == 3'd0;

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			req.valid <= 1'b0;
			charSeen <= 1'b0;
			ptrSeen <= '0;
			for (int i = 0; i < vicTimingPkg::MIBCNT; i++)
				sprCnt[i] <= 6'd0;
		end else begin
			// Output stage holds while the issue block has no room
			if (stageFree)
				req.valid <= take;
			if (ret.charValid)
				charSeen <= 1'b1;
			if (ret.ptrValid)
				ptrSeen[ret.ptrNum] <= 1'b1;
			if (take && kindNext == vicMemPkg::kindMatrix)
				charSeen <= 1'b0;
			if (take && kindNext == vicMemPkg::kindSprPtr)
				ptrSeen[slot.spriteNum] <= 1'b0;
			if (frameStart) begin
				for (int i = 0; i < vicTimingPkg::MIBCNT; i++)
					sprCnt[i] <= 6'd0;
			end
			if (take && kindNext == vicMemPkg::kindSprData)
				sprCnt[slot.spriteNum] <= sprCnt[slot.spriteNum] + 6'd1;
		end
	end

	// Request payload and returned words
	always_ff @(posedge clk33) begin
		if (take) begin
			req.addr <= addrNext;
			req.kind <= kindNext;
			req.spriteNum <= slot.spriteNum;
		end
		if (ret.charValid)
			charCode <= ret.charCode;
		if (ret.ptrValid)
			sprPtr[ret.ptrNum] <= ret.ptrValue;
	end

endmodule

/* logic/vicFetchIssue.sv */
/*
 * Fetch issue block for the video fetch engine.
 * Credit counter, in-order queue of requests in flight, and
 * decode of returned words for the address generator and pixel side.
 */
`timescale 1ns/1ns

module vicFetchIssue (
	input logic clk33,
	input logic arstN,
	input logic memCredit,
	input logic memRdValid,
	input logic [vicMemPkg::DATA_W-1:0] memRdData,
	fetchReqIf.sink req,
	fetchRetIf.source ret,
	output logic memReqValid,
	output logic [vicMemPkg::ADDR_W-1:0] memAddr,
	output vicMemPkg::fetchKind_e memKindOut,
	output logic pixValid,
	output vicMemPkg::fetchKind_e pixKind,
	output logic [vicMemPkg::DATA_W-1:0] pixData
);

	logic [2:0] creditCnt;
	vicMemPkg::fetchKind_e qKind [vicMemPkg::CREDITS];
	logic [2:0] qSpr [vicMemPkg::CREDITS];
	logic [1:0] wrPtr;
	logic [1:0] rdPtr;
	logic [2:0] qCount;
	logic issue;
	logic pop;
	vicMemPkg::fetchKind_e headKind;
	logic [2:0] headSpr;
	vicMemPkg::fetchWord_u rdWord;

	// ============================================================
	// Request side
	// ============================================================

	// Room needs both a credit and a free queue entry
	assign req.ready = (creditCnt != 3'd0) && (qCount != 3'(vicMemPkg::CREDITS));
	assign issue = req.valid && req.ready;

	assign memReqValid = issue;
	assign memAddr = req.addr;
	assign memKindOut = req.kind;

	// Words come back in request order, so the head of the queue tags them
	assign pop = memRdValid && (qCount != 3'd0);
	assign headKind = qKind[rdPtr];
	assign headSpr = qSpr[rdPtr];
	assign rdWord = memRdData;

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			creditCnt <= 3'(vicMemPkg::CREDITS);
			wrPtr <= 2'd0;
			rdPtr <= 2'd0;
			qCount <= 3'd0;
		end else begin
			case ({issue, memCredit})
				2'b10: creditCnt <= creditCnt - 3'd1;
				2'b01: creditCnt <= creditCnt + 3'd1;
				default: ;
			endcase
			if (issue)
				wrPtr <= wrPtr + 2'd1;
			if (pop)
				rdPtr <= rdPtr + 2'd1;
			case ({issue, pop})
				2'b10: qCount <= qCount + 3'd1;
				2'b01: qCount <= qCount - 3'd1;
				default: ;
			endcase
		end
	end

	// Queue entries carry only the kind and sprite number
	always_ff @(posedge clk33) begin
		if (issue) begin
			qKind[wrPtr] <= req.kind;
			qSpr[wrPtr] <= req.spriteNum;
		end
	end

	// ============================================================
	// Return side
	// ============================================================

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			pixValid <= 1'b0;
			ret.charValid <= 1'b0;
			ret.ptrValid <= 1'b0;
		end else begin
			// Refresh words end here and never reach the pixel pipeline
			pixValid <= pop && headKind != vicMemPkg::kindRef;
			ret.charValid <= pop && headKind == vicMemPkg::kindMatrix;
			ret.ptrValid <= pop && headKind == vicMemPkg::kindSprPtr;
		end
	end

	always_ff @(posedge clk33) begin
		if (pop) begin
			pixKind <= headKind;
			pixData <= memRdData;
			ret.charCode <= rdWord.matrix.code;
			ret.ptrNum <= headSpr;
			ret.ptrValue <= rdWord.ptr.pointer;
		end
	end

endmodule

/* logic/vicFetchTop.sv */
/*
 * Top level of the video fetch engine.
 * Sequencer, address generator and issue block joined by interfaces.
 */
`timescale 1ns/1ns

module vicFetchTop (
	input logic clk33,
	input logic arstN,
	input logic col80,
	input logic bmm,
	input logic ecm,
	input logic [13:0] vm,
	input logic [13:0] cb,
	output logic memReqValid,
	output logic [vicMemPkg::ADDR_W-1:0] memAddr,
	output vicMemPkg::fetchKind_e memKindOut,
	input logic memCredit,
	input logic memRdValid,
	input logic [vicMemPkg::DATA_W-1:0] memRdData,
	output logic pixValid,
	output vicMemPkg::fetchKind_e pixKind,
	output logic [vicMemPkg::DATA_W-1:0] pixData
);

	slotIf slotBus ();
	fetchReqIf reqBus ();
	fetchRetIf retBus ();

	// Input side walks the raster
	vicSlotSequencer uSeq (
		.clk33 (clk33),
		.arstN (arstN),
		.slot (slotBus.source)
	);

	// Slot to address, one registered stage
	vicAddressGen uAddrGen (
		.clk33 (clk33),
		.arstN (arstN),
		.col80 (col80),
		.bmm (bmm),
		.ecm (ecm),
		.vm (vm),
		.cb (cb),
		.slot (slotBus.sink),
		.req (reqBus.source),
		.ret (retBus.sink)
	);

	// Credit flow control toward memory and in-order return
	vicFetchIssue uIssue (
		.clk33 (clk33),
		.arstN (arstN),
		.memCredit (memCredit),
		.memRdValid (memRdValid),
		.memRdData (memRdData),
		.req (reqBus.sink),
		.ret (retBus.source),
		.memReqValid (memReqValid),
		.memAddr (memAddr),
		.memKindOut (memKindOut),
		.pixValid (pixValid),
		.pixKind (pixKind),
		.pixData (pixData)
	);

endmodule

/* tests/vicFetch_props.sv */
/*
 * Bound checks for the video fetch engine top level.
 * Models the line layout and memory rule from the top-level ports,
 * then checks addresses, kinds, credits, reset state and return order.
 */
`timescale 1ns/1ns

module vicFetchProps (
	input logic clk33,
	input logic arstN,
	input logic col80,
	input logic bmm,
	input logic ecm,
	input logic [13:0] vm,
	input logic [13:0] cb,
	input logic memReqValid,
	input logic [13:0] memAddr,
	input vicMemPkg::fetchKind_e memKindOut,
	input logic memCredit,
	input logic memRdValid,
	input logic pixValid,
	input vicMemPkg::fetchKind_e pixKind,
	input logic [11:0] pixData
);

	// Slot position within the line, as seen from issued requests
	logic [6:0] slotIdx;
	logic [7:0] lineNum;
	logic [7:0] refCnt;
	logic [7:0] lastCode;
	logic [7:0] sprPtr [8];
	logic [5:0] sprCnt [8];
	logic [2:0] creditCnt;
	// Requests issued whose word has not come back yet
	logic [3:0] inFlight;
	logic [2:0] modeQ;
	logic stale;
	logic skip;
	vicMemPkg::fetchKind_e pixKindQ [8];
	logic [11:0] pixDataQ [8];
	logic [2:0] headPtr;
	logic [2:0] tailPtr;
	logic [3:0] pixPending;
	logic [11:0] retWord;
	int colIdx;
	int sprNum;
	int sprPart;
	int lineSlots;
	logic [10:0] vmIdx;
	logic [2:0] scan;
	logic [13:0] expAddr;
	vicMemPkg::fetchKind_e expKind;

	// One flag per check, all gathered into failSeen for the testbench
	logic badAddr = 1'b0;
	logic badKind = 1'b0;
	logic badCredit = 1'b0;
	logic badOutstanding = 1'b0;
	logic badReset = 1'b0;
	logic badPixel = 1'b0;
	logic failSeen;

	assign failSeen = badAddr || badKind || badCredit || badOutstanding || badReset || badPixel;

	// ============================================================
	// Expected request for the current slot
	// ============================================================

	assign lineSlots = vicTimingPkg::REF_SLOTS + 2 * vicTimingPkg::CHAR_COLS +
		vicTimingPkg::MIBCNT * (1 + vicTimingPkg::SPR_DATA);
	assign retWord = memAddr[11:0] ^ 12'hA5A;
	assign scan = 3'(lineNum % vicTimingPkg::ROW_LINES);

	always_comb begin
		colIdx = 0;
		sprNum = 0;
		sprPart = 0;
		expAddr = 14'h3FFF;
		expKind = vicMemPkg::kindRef;
		if (int'(slotIdx) >= vicTimingPkg::REF_SLOTS + 2 * vicTimingPkg::CHAR_COLS) begin
			sprNum = (int'(slotIdx) - vicTimingPkg::REF_SLOTS - 2 * vicTimingPkg::CHAR_COLS) /
				(1 + vicTimingPkg::SPR_DATA);
			sprPart = (int'(slotIdx) - vicTimingPkg::REF_SLOTS - 2 * vicTimingPkg::CHAR_COLS) %
				(1 + vicTimingPkg::SPR_DATA);
		end else if (int'(slotIdx) >= vicTimingPkg::REF_SLOTS)
			colIdx = (int'(slotIdx) - vicTimingPkg::REF_SLOTS) / 2;
		vmIdx = 11'((lineNum / vicTimingPkg::ROW_LINES) * vicTimingPkg::CHAR_COLS + colIdx);
		if (int'(slotIdx) < vicTimingPkg::REF_SLOTS)
			expAddr = {6'h3F, refCnt};
		else if (int'(slotIdx) < vicTimingPkg::REF_SLOTS + 2 * vicTimingPkg::CHAR_COLS) begin
			if (((int'(slotIdx) - vicTimingPkg::REF_SLOTS) % 2) == 0) begin
				expKind = vicMemPkg::kindMatrix;
				expAddr = vm + 14'(vmIdx);
			end else begin
				expKind = vicMemPkg::kindGfx;
				if (bmm)
					expAddr = 14'((int'(cb[13]) << 12) + (int'(vmIdx) << 3) + int'(scan));
				else
					expAddr = {cb[13:11], lastCode, scan};
				if (ecm)
					expAddr[10:9] = 2'b00;
			end
		end else if (sprPart == 0) begin
			expKind = vicMemPkg::kindSprPtr;
			expAddr = vm + (col80 ? vicMemPkg::SPR_PTR80 : vicMemPkg::SPR_PTR40) + 14'(sprNum);
		end else begin
			expKind = vicMemPkg::kindSprData;
			expAddr = {sprPtr[sprNum], sprCnt[sprNum]};
		end
	end

	// A request formed before a mode change may still be in the output stage
	assign skip = stale || (modeQ != {col80, bmm, ecm});

	// ============================================================
	// Model state, stepped by issued requests and returns
	// ============================================================

	always_ff @(posedge clk33 or negedge arstN) begin
		if (!arstN) begin
			slotIdx <= '0;
			lineNum <= '0;
			refCnt <= 8'hFF;
			creditCnt <= 3'(vicMemPkg::CREDITS);
			inFlight <= '0;
			modeQ <= '0;
			stale <= 1'b0;
			headPtr <= '0;
			tailPtr <= '0;
			pixPending <= '0;
			for (int i = 0; i < 8; i++)
				sprCnt[i] <= '0;
		end else begin
			modeQ <= {col80, bmm, ecm};
			if (memReqValid)
				stale <= 1'b0;
			else if (modeQ != {col80, bmm, ecm})
				stale <= 1'b1;
			creditCnt <= creditCnt + 3'(memCredit) - 3'(memReqValid);
			inFlight <= inFlight + 4'(memReqValid) - 4'(memRdValid);
			pixPending <= pixPending + 4'(memReqValid && memKindOut != vicMemPkg::kindRef) -
				4'(pixValid);
			if (pixValid)
				headPtr <= headPtr + 3'd1;
			if (memReqValid) begin
				if (int'(slotIdx) == lineSlots - 1) begin
					slotIdx <= '0;
					lineNum <= (int'(lineNum) ==
						vicTimingPkg::ROW_LINES * vicTimingPkg::TEXT_ROWS - 1) ?
						8'd0 : lineNum + 8'd1;
				end else
					slotIdx <= slotIdx + 7'd1;
				if (expKind == vicMemPkg::kindRef)
					refCnt <= refCnt - 8'd1;
				else begin
					pixKindQ[tailPtr] <= expKind;
					pixDataQ[tailPtr] <= retWord;
					tailPtr <= tailPtr + 3'd1;
				end
				// Code and pointer follow from the real address through the memory rule
				if (expKind == vicMemPkg::kindMatrix) begin
					lastCode <= retWord[7:0];
					if (colIdx == 0 && lineNum == 8'd0) begin
						for (int i = 0; i < 8; i++)
							sprCnt[i] <= '0;
					end
				end
				if (expKind == vicMemPkg::kindSprPtr)
					sprPtr[sprNum] <= retWord[7:0];
				if (expKind == vicMemPkg::kindSprData)
					sprCnt[sprNum] <= sprCnt[sprNum] + 6'd1;
			end
		end
	end

	// ============================================================
	// Assertions
	// ============================================================

	addrCheck: assert property (@(posedge clk33) disable iff (!arstN)
		memReqValid && !skip |-> memAddr == expAddr)
	else begin
		badAddr = 1'b1;
		$error("FAIL request address expected %h actual %h", expAddr, memAddr);
	end

	kindCheck: assert property (@(posedge clk33) disable iff (!arstN)
		memReqValid |-> memKindOut == expKind)
	else begin
		badKind = 1'b1;
		$error("FAIL request kind expected %0d actual %0d", expKind, memKindOut);
	end

	creditCheck: assert property (@(posedge clk33) disable iff (!arstN)
		memReqValid |-> creditCnt != 3'd0)
	else begin
		badCredit = 1'b1;
		$error("A request was issued with no credit left");
	end

	outstandingCheck: assert property (@(posedge clk33) disable iff (!arstN)
		inFlight <= 4'(vicMemPkg::CREDITS))
	else begin
		badOutstanding = 1'b1;
		$error("More requests were in flight than the memory can hold");
	end

	resetCheck: assert property (@(posedge clk33) !arstN |-> !memReqValid && !pixValid)
	else begin
		badReset = 1'b1;
		$error("A valid output was high during reset");
	end

	pixelCheck: assert property (@(posedge clk33) disable iff (!arstN)
		pixValid |-> pixPending != 4'd0 && pixKind == pixKindQ[headPtr] &&
		pixData == pixDataQ[headPtr])
	else begin
		badPixel = 1'b1;
		$error("FAIL pixel word expected %0d/%h actual %0d/%h",
			pixKindQ[headPtr], pixDataQ[headPtr], pixKind, pixData);
	end

endmodule

bind vicFetchTop vicFetchProps uProps (
	.clk33 (clk33),
	.arstN (arstN),
	.col80 (col80),
	.bmm (bmm),
	.ecm (ecm),
	.vm (vm),
	.cb (cb),
	.memReqValid (memReqValid),
	.memAddr (memAddr),
	.memKindOut (memKindOut),
	.memCredit (memCredit),
	.memRdValid (memRdValid),
	.pixValid (pixValid),
	.pixKind (pixKind),
	.pixData (pixData)
);

/* tests/vicFetchTb.sv */
/*
 * Testbench for the video fetch engine.
 * Clock, reset, mode phases over two frames, and a memory model
 * with random latency and withheld credits.
 */
`timescale 1ns/1ns

module vicFetchTb;

	logic clk33;
	logic arstN;
	logic col80;
	logic bmm;
	logic ecm;
	logic [13:0] vm;
	logic [13:0] cb;
	logic memReqValid;
	logic [13:0] memAddr;
	vicMemPkg::fetchKind_e memKindOut;
	logic memCredit;
	logic memRdValid;
	logic [11:0] memRdData;
	logic pixValid;
	vicMemPkg::fetchKind_e pixKind;
	logic [11:0] pixData;

	integer seed;
	int cycle;
	int reqCount;
	int pixCount;
	int creditsOwed;
	int holdLeft;
	int frameReqs;
	// Words waiting in the memory, with the cycle each becomes due
	logic [11:0] pendData [$];
	int pendDue [$];

	initial begin
		clk33 = 1'b0;
		forever #2 clk33 = ~clk33;
	end

	vicFetchTop i_dut (
		.clk33 (clk33),
		.arstN (arstN),
		.col80 (col80),
		.bmm (bmm),
		.ecm (ecm),
		.vm (vm),
		.cb (cb),
		.memReqValid (memReqValid),
		.memAddr (memAddr),
		.memKindOut (memKindOut),
		.memCredit (memCredit),
		.memRdValid (memRdValid),
		.memRdData (memRdData),
		.pixValid (pixValid),
		.pixKind (pixKind),
		.pixData (pixData)
	);

	// ============================================================
	// Memory model
	// ============================================================

	always @(posedge clk33) begin : memoryModel
		int lat;
		if (arstN) begin
			cycle++;
			if (memReqValid) begin
				lat = 1 + int'($unsigned($random(seed)) % 6);
				pendData.push_back(memAddr[11:0] ^ 12'hA5A);
				pendDue.push_back(cycle + lat);
				reqCount++;
			end
			memRdValid <= 1'b0;
			if (pendDue.size() != 0 && pendDue[0] <= cycle) begin
				memRdValid <= 1'b1;
				memRdData <= pendData.pop_front();
				void'(pendDue.pop_front());
				creditsOwed++;
			end
			// Credits come back after the word, but now and then they are held
			memCredit <= 1'b0;
			if (holdLeft > 0)
				holdLeft--;
			else if (creditsOwed > 0) begin
				memCredit <= 1'b1;
				creditsOwed--;
			end
			if ($unsigned($random(seed)) % 64 == 0)
				holdLeft = 4 + int'($unsigned($random(seed)) % 16);
			if (pixValid)
				pixCount++;
		end
	end

	// ============================================================
	// Checks and run control
	// ============================================================

	task automatic failRun(input string why);
		$display("tests failed");
		$fatal(1, "%s", why);
	endtask

	// Any bound assertion failing ends the run here
	always @(posedge clk33) begin
		if (i_dut.uProps.failSeen)
			failRun("a bound assertion on the DUT failed");
	end

	task automatic waitRequests(input int target);
		int waited;
		waited = 0;
		while (reqCount < target) begin
			@(posedge clk33);
			waited++;
			if (waited > 200000)
				failRun("timeout waiting for memory requests");
		end
	endtask

	task automatic waitPixels(input int target);
		int waited;
		waited = 0;
		while (pixCount < target) begin
			@(posedge clk33);
			waited++;
			if (waited > 200000)
				failRun("timeout waiting for pixel words");
		end
	endtask

	initial begin
		seed = 32'h17b0;
		arstN = 1'b0;
		col80 = 1'b0;
		bmm = 1'b0;
		ecm = 1'b0;
		vm = 14'h0400;
		cb = 14'h3800;
		memCredit = 1'b0;
		memRdValid = 1'b0;
		memRdData = 12'h000;
		cycle = 0;
		reqCount = 0;
		pixCount = 0;
		creditsOwed = 0;
		holdLeft = 0;
		frameReqs = (vicTimingPkg::REF_SLOTS + 2 * vicTimingPkg::CHAR_COLS +
			vicTimingPkg::MIBCNT * (1 + vicTimingPkg::SPR_DATA)) *
			vicTimingPkg::ROW_LINES * vicTimingPkg::TEXT_ROWS;
		repeat (10) @(posedge clk33);
		arstN <= 1'b1;

		// Text mode for the first half frame, then bitmap
		waitRequests(frameReqs / 2);
		bmm <= 1'b1;
		waitRequests(frameReqs);
		bmm <= 1'b0;
		ecm <= 1'b1;
		waitRequests(frameReqs * 3 / 2);
		ecm <= 1'b0;
		col80 <= 1'b1;
		waitRequests(frameReqs * 2);

		// Every non-refresh request of both frames must come back
		waitPixels(frameReqs * 2 - 2 * vicTimingPkg::REF_SLOTS *
			vicTimingPkg::ROW_LINES * vicTimingPkg::TEXT_ROWS);
		repeat (2) @(posedge clk33);
		if (i_dut.uProps.failSeen)
			failRun("a bound assertion on the DUT failed");
		else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

/* sim.f */
logic/vicTimingPkg.sv
logic/vicMemPkg.sv
logic/vicIfs.sv
logic/vicSlotSequencer.sv
logic/vicAddressGen.sv
logic/vicFetchIssue.sv
logic/vicFetchTop.sv
tests/vicFetch_props.sv
tests/vicFetchTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= vicFetchTb
OBJ_DIR ?= obj_dir
FLIST ?= sim.f
VFLAGS ?= --binary --timing --assert -j 0
RUN_ARGS ?= +verilator+error+limit+100
PASS_MSG ?= all tests passed

SRCS := $(shell cat $(FLIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
